/* Bender.yml */
package:
  name: gmii_rx_frontend

sources:
  - src/gmii_rx_pkg.sv
  - src/gmii_fcs_strip.sv
  - src/gmii_preamble_check.sv
  - src/gmii_frame_length.sv
  - src/gmii_rx_frontend.sv
  - target: test
    files:
      - verification/gmii_rx_frontend_tb.sv

/* src/gmii_fcs_strip.sv */
// GMII input register and FCS removal
// Four-byte delay line that never releases the trailing check sequence

module gmii_fcs_strip (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                rx_dv,
    input  logic                                rx_er,
    input  logic [gmii_rx_pkg::GMII_DATA_W-1:0] rxd,
    output gmii_rx_pkg::gmii_beat_t             fcs_beat
);
    import gmii_rx_pkg::*;

    gmii_beat_t                       in_q;
    gmii_beat_t                       line [FCS_BYTES];
    logic                             dv_q;
    logic                             frame_end;
    logic                             line_full;
    logic                             out_dv;
    logic [$clog2(FCS_BYTES+1)-1:0]   fill;

    assign frame_end = dv_q && !in_q.dv;
    assign line_full = (fill == FCS_BYTES);

    //////////////////////////////////////////////////
    // Input register and fill tracking
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_q <= '0;
            dv_q <= 1'b0;
            fill <= '0;
        end else begin
            in_q.dv   <= rx_dv;
            in_q.er   <= rx_er;
            in_q.data <= rxd;
            dv_q      <= in_q.dv;
            if (frame_end) begin
                fill <= '0;
            end else if (in_q.dv && !line_full) begin
                fill <= fill + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Delay line
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (frame_end) begin
            // Held FCS bytes are flushed here
            for (int i = 0; i < FCS_BYTES; i++) begin
                line[i] <= '0;
            end
        end else begin
            line[0] <= in_q;
            for (int i = 1; i < FCS_BYTES; i++) begin
                line[i] <= line[i-1];
            end
        end
    end

    // Oldest byte leaves only while a later byte of the same frame is still arriving
    assign out_dv = line_full && in_q.dv && line[FCS_BYTES-1].dv;

    assign fcs_beat.dv   = out_dv;
    assign fcs_beat.er   = out_dv && line[FCS_BYTES-1].er;
    assign fcs_beat.data = line[FCS_BYTES-1].data;

endmodule

/* src/gmii_frame_length.sv */
// Frame length enforcement
// Pads short frames with zero bytes and truncates long ones

module gmii_frame_length (
    input  logic                    clk,
    input  logic                    rst_n,
    input  gmii_rx_pkg::gmii_beat_t in_beat,
    output gmii_rx_pkg::gmii_beat_t out_beat
);
    import gmii_rx_pkg::*;

    length_state_t           state;
    logic [FRAME_CNT_W-1:0]  cnt;
    logic                    dv_q;
    logic                    frame_start;
    logic                    frame_end;
    gmii_beat_t              pad_beat;

    assign frame_start = in_beat.dv && !dv_q;
    assign frame_end   = dv_q && !in_beat.dv;

    assign pad_beat.dv   = 1'b1;
    assign pad_beat.er   = 1'b0;
    assign pad_beat.data = '0;

    //////////////////////////////////////////////////
    // Length FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= LEN_IDLE;
            cnt      <= '0;
            dv_q     <= 1'b0;
            out_beat <= '0;
        end else begin
            dv_q <= in_beat.dv;
            case (state)
                LEN_IDLE: begin
                    // A frame already running is not picked up midway
                    if (frame_start) begin
                        out_beat <= in_beat;
                        cnt      <= 11'd1;
                        state    <= LEN_PASS;
                    end else begin
                        out_beat <= '0;
                        cnt      <= '0;
                    end
                end
                LEN_PASS: begin
                    if (frame_end) begin
                        if (cnt < MIN_FRAME_BYTES) begin
                            // First pad byte follows the last data byte directly
                            out_beat <= pad_beat;
                            cnt      <= cnt + 1'b1;
                            state    <= LEN_PAD;
                        end else begin
                            out_beat <= '0;
                            state    <= LEN_IDLE;
                        end
                    end else if (cnt == MAX_FRAME_BYTES) begin
                        out_beat <= '0;
                        state    <= LEN_DISCARD;
                    end else begin
                        out_beat <= in_beat;
                        cnt      <= cnt + 1'b1;
                    end
                end
                LEN_PAD: begin
                    if (cnt < MIN_FRAME_BYTES) begin
                        out_beat <= pad_beat;
                        cnt      <= cnt + 1'b1;
                    end else begin
                        out_beat <= '0;
                        state    <= LEN_IDLE;
                    end
                end
                LEN_DISCARD: begin
                    out_beat <= '0;
                    if (frame_end) begin
                        state <= LEN_IDLE;
                    end
                end
                default: begin
                    out_beat <= '0;
                    state    <= LEN_IDLE;
                end
            endcase
        end
    end

endmodule

/* src/gmii_preamble_check.sv */
// Preamble and SFD recognizer
// Strips preamble and delimiter, drops frames with a malformed preamble

module gmii_preamble_check (
    input  logic                    clk,
    input  logic                    rst_n,
    input  gmii_rx_pkg::gmii_beat_t in_beat,
    output gmii_rx_pkg::gmii_beat_t out_beat
);
    import gmii_rx_pkg::*;

    preamble_state_t state;
    preamble_state_t state_nxt;
    logic            dv_q;
    logic            frame_end;
    logic            is_pre;
    logic            is_sfd;

    assign frame_end = dv_q && !in_beat.dv;
    assign is_pre    = (in_beat.data == PREAMBLE_BYTE);
    assign is_sfd    = (in_beat.data == SFD_BYTE);

    //////////////////////////////////////////////////
    // Next state
    //////////////////////////////////////////////////

    always_comb begin
        state_nxt = state;
        case (state)
            // Out of reset wait for an idle line before arming
            PRE_IDLE: begin
                if (!in_beat.dv) begin
                    state_nxt = PRE_FIRST;
                end
            end
            PRE_FIRST: begin
                if (in_beat.dv) begin
                    state_nxt = is_pre ? PRE_HUNT : PRE_DROP;
                end
            end
            PRE_HUNT: begin
                if (frame_end) begin
                    // No delimiter seen
                    state_nxt = PRE_FIRST;
                end else if (in_beat.dv) begin
                    if (is_sfd) begin
                        state_nxt = PRE_PASS;
                    end else if (!is_pre) begin
                        state_nxt = PRE_DROP;
                    end
                end
            end
            PRE_PASS, PRE_DROP: begin
                if (frame_end) begin
                    state_nxt = PRE_FIRST;
                end
            end
            default: begin
                state_nxt = PRE_IDLE;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // State and output registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= PRE_IDLE;
            dv_q     <= 1'b0;
            out_beat <= '0;
        end else begin
            state <= state_nxt;
            dv_q  <= in_beat.dv;
            if (state == PRE_PASS && in_beat.dv) begin
                out_beat <= in_beat;
            end else begin
                out_beat <= '0;
            end
        end
    end

endmodule

/* src/gmii_rx_frontend.sv */
// GMII receive front end top level
// FCS strip, preamble check and length control in series

module gmii_rx_frontend (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                rx_dv,
    input  logic                                rx_er,
    input  logic [gmii_rx_pkg::GMII_DATA_W-1:0] rxd,
    output logic                                out_dv,
    output logic                                out_er,
    output logic [gmii_rx_pkg::GMII_DATA_W-1:0] out_data
);
    import gmii_rx_pkg::*;

    gmii_beat_t fcs_beat;
    gmii_beat_t pre_beat;
    gmii_beat_t len_beat;

    //////////////////////////////////////////////////
    // Stage chain
    //////////////////////////////////////////////////

    gmii_fcs_strip u_fcs_strip (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx_dv    (rx_dv),
        .rx_er    (rx_er),
        .rxd      (rxd),
        .fcs_beat (fcs_beat)
    );

    gmii_preamble_check u_preamble_check (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_beat  (fcs_beat),
        .out_beat (pre_beat)
    );

    gmii_frame_length u_frame_length (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_beat  (pre_beat),
        .out_beat (len_beat)
    );

    assign out_dv   = len_beat.dv;
    assign out_er   = len_beat.er;
    assign out_data = len_beat.data;

endmodule

/* src/gmii_rx_pkg.sv */
// Shared types and constants for the GMII receive front end
// Beat struct, FSM state encodings and Ethernet frame limits

package gmii_rx_pkg;

    //////////////////////////////////////////////////
    // Frame constants
    //////////////////////////////////////////////////

    localparam int GMII_DATA_W = 8;
    localparam int FCS_BYTES   = 4;
    localparam int FRAME_CNT_W = 11;

    localparam logic [GMII_DATA_W-1:0] PREAMBLE_BYTE = 8'h55;
    localparam logic [GMII_DATA_W-1:0] SFD_BYTE      = 8'hD5;

    // Limits exclude the FCS
    localparam logic [FRAME_CNT_W-1:0] MIN_FRAME_BYTES = 11'd60;
    localparam logic [FRAME_CNT_W-1:0] MAX_FRAME_BYTES = 11'd1514;

    //////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////

    // One GMII byte time
    typedef struct packed {
        logic                   dv;
        logic                   er;
        logic [GMII_DATA_W-1:0] data;
    } gmii_beat_t;

    typedef enum logic [2:0] {
        PRE_IDLE,
        PRE_FIRST,
        PRE_HUNT,
        PRE_PASS,
        PRE_DROP
    } preamble_state_t;

    typedef enum logic [1:0] {
        LEN_IDLE,
        LEN_PASS,
        LEN_PAD,
        LEN_DISCARD
    } length_state_t;

endpackage

/* tb.f */
src/gmii_rx_pkg.sv
src/gmii_fcs_strip.sv
src/gmii_preamble_check.sv
src/gmii_frame_length.sv
src/gmii_rx_frontend.sv
verification/gmii_rx_frontend_tb.sv

/* verification/gmii_rx_frontend_tb.sv */
// Directed testbench for the GMII receive front end
// Clock, reset, frame driver, output collector and reference model
// Tests cover FCS strip, preamble check, padding, truncation and er

module gmii_rx_frontend_tb;

    localparam int GAP_CYCLES     = 64;
    localparam int PRE_LEN        = 7;
    localparam int FCS_LEN        = 4;
    localparam int MIN_LEN        = 60;
    localparam int MAX_LEN        = 1514;
    localparam int FRONT_LATENCY  = 7;
    // Several times the cycles used by all tests together
    localparam int TIMEOUT_CYCLES = 12000;

    logic       clk;
    logic       rst_n;
    logic       rx_dv;
    logic       rx_er;
    logic [7:0] rxd;
    logic       out_dv;
    logic       out_er;
    logic [7:0] out_data;

    integer     seed;
    int         errors;
    int         cycle_cnt = 0;
    int         drive_edge;
    int         first_out_cycle;

    logic [7:0] payload[$];
    logic [7:0] exp_data[$];
    logic       exp_er[$];
    logic [7:0] got_data[$];
    logic       got_er[$];
    int         got_cycle[$];

    gmii_rx_frontend uut (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx_dv    (rx_dv),
        .rx_er    (rx_er),
        .rxd      (rxd),
        .out_dv   (out_dv),
        .out_er   (out_er),
        .out_data (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Cycle counter, timeout and output collector
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Errors: %0d", errors);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // Outputs settle after the rising edge, so sample on the falling one
    always @(negedge clk) begin
        if (rst_n && out_dv) begin
            if (got_data.size() == 0) begin
                first_out_cycle = cycle_cnt;
            end
            got_data.push_back(out_data);
            got_er.push_back(out_er);
            got_cycle.push_back(cycle_cnt);
        end
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            errors++;
            $display("mismatch at time %0t: %s = 0x%0h, expected 0x%0h",
                     $time, name, got, expected);
        end
    endtask

    task automatic drive_byte(input logic [7:0] b, input logic er);
        @(posedge clk);
        rx_dv <= 1'b1;
        rx_er <= er;
        rxd   <= b;
    endtask

    task automatic drive_idle(input int n);
        repeat (n) begin
            @(posedge clk);
            rx_dv <= 1'b0;
            rx_er <= 1'b0;
            rxd   <= 8'h00;
        end
    endtask

    task automatic make_payload(input int len);
        logic [31:0] r;
        payload.delete();
        for (int i = 0; i < len; i++) begin
            r = $random(seed);
            payload.push_back(r[7:0]);
        end
    endtask

    task automatic clear_capture();
        got_data.delete();
        got_er.delete();
        got_cycle.delete();
        first_out_cycle = -1;
    endtask

    // Preamble, SFD, payload, random FCS, then the inter-frame gap
    task automatic send_frame(input int bad_pre_pos, input bit omit_sfd, input int err_pos);
        logic [31:0] r;
        for (int i = 0; i < PRE_LEN; i++) begin
            drive_byte((i == bad_pre_pos) ? 8'h5A : 8'h55, 1'b0);
        end
        drive_byte(omit_sfd ? 8'h55 : 8'hD5, 1'b0);
        for (int i = 0; i < payload.size(); i++) begin
            drive_byte(payload[i], i == err_pos);
            // Counter steps on this same edge
            if (i == 0) begin
                drive_edge = cycle_cnt + 1;
            end
        end
        for (int i = 0; i < FCS_LEN; i++) begin
            r = $random(seed);
            drive_byte(r[7:0], 1'b0);
        end
        drive_idle(GAP_CYCLES);
    endtask

    // Reference model truncates at MAX_LEN and zero pads up to MIN_LEN
    task automatic build_expected(input bit dropped, input int err_pos);
        int n;
        exp_data.delete();
        exp_er.delete();
        if (!dropped) begin
            n = (payload.size() > MAX_LEN) ? MAX_LEN : payload.size();
            for (int i = 0; i < n; i++) begin
                exp_data.push_back(payload[i]);
                exp_er.push_back(i == err_pos);
            end
            while (exp_data.size() < MIN_LEN) begin
                exp_data.push_back(8'h00);
                exp_er.push_back(1'b0);
            end
        end
    endtask

    task automatic wait_for_bytes(input int n);
        while (got_data.size() < n) begin
            @(negedge clk);
        end
    endtask

    task automatic compare_frame(input string label);
        int n;
        wait_for_bytes(exp_data.size());
        check_value({label, " byte count"}, got_data.size(), exp_data.size());
        n = (got_data.size() < exp_data.size()) ? got_data.size() : exp_data.size();
        for (int i = 0; i < n; i++) begin
            check_value($sformatf("%s out_data[%0d]", label, i), got_data[i], exp_data[i]);
            check_value($sformatf("%s out_er[%0d]", label, i), got_er[i], exp_er[i]);
        end
        // Bytes of one frame leave on consecutive cycles
        for (int i = 1; i < got_cycle.size(); i++) begin
            check_value($sformatf("%s out_dv cycle step before byte %0d", label, i),
                        got_cycle[i] - got_cycle[i-1], 1);
        end
    endtask

    task automatic check_latency(input string label);
        if (first_out_cycle < 0) begin
            errors++;
            $display("%s: no output byte arrived, latency not measured", label);
        end else begin
            check_value({label, " first byte latency"},
                        first_out_cycle - drive_edge, FRONT_LATENCY);
        end
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////

    task automatic normal_frame_test();
        clear_capture();
        make_payload(100);
        send_frame(-1, 1'b0, -1);
        build_expected(1'b0, -1);
        compare_frame("normal");
        check_latency("normal");
    endtask

    task automatic short_frame_test();
        clear_capture();
        make_payload(20);
        send_frame(-1, 1'b0, -1);
        build_expected(1'b0, -1);
        compare_frame("short");
    endtask

    task automatic long_frame_test();
        clear_capture();
        make_payload(1600);
        send_frame(-1, 1'b0, -1);
        build_expected(1'b0, -1);
        compare_frame("long");
    endtask

    task automatic bad_preamble_test();
        // 0x5A inside the preamble
        clear_capture();
        make_payload(60);
        send_frame(3, 1'b0, -1);
        build_expected(1'b1, -1);
        compare_frame("bad preamble");

        // All 0x55 with no delimiter anywhere
        clear_capture();
        payload.delete();
        for (int i = 0; i < 60; i++) begin
            payload.push_back(8'h55);
        end
        send_frame(-1, 1'b1, -1);
        build_expected(1'b1, -1);
        compare_frame("missing sfd");

        clear_capture();
        make_payload(80);
        send_frame(-1, 1'b0, -1);
        build_expected(1'b0, -1);
        compare_frame("after bad preamble");
    endtask

    task automatic error_propagation_test();
        clear_capture();
        make_payload(100);
        send_frame(-1, 1'b0, 30);
        build_expected(1'b0, 30);
        compare_frame("rx_er");
    endtask

    task automatic frame_sequence_test();
        logic [31:0] r;
        int          len;
        for (int f = 0; f < 3; f++) begin
            r   = $random(seed);
            len = 10 + int'(r % 191);
            clear_capture();
            make_payload(len);
            send_frame(-1, 1'b0, -1);
            build_expected(1'b0, -1);
            compare_frame($sformatf("sequence %0d (len %0d)", f, len));
            check_latency($sformatf("sequence %0d", f));
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        seed            = 32'habd3dfae;
        errors          = 0;
        drive_edge      = 0;
        first_out_cycle = -1;
        rst_n           = 1'b0;
        rx_dv           = 1'b0;
        rx_er           = 1'b0;
        rxd             = 8'h00;

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        drive_idle(4);

        @(negedge clk);
        check_value("out_dv after reset", out_dv, 1'b0);
        check_value("out_er after reset", out_er, 1'b0);
        check_value("out_data after reset", out_data, 8'h00);

        normal_frame_test();
        short_frame_test();
        long_frame_test();
        bad_preamble_test();
        error_propagation_test();
        frame_sequence_test();

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
